/* common/prefetch_config.svh */
// Prefetcher configuration
`ifndef PREFETCH_CONFIG_SVH
`define PREFETCH_CONFIG_SVH

// log2 of the queue depth, 8 slots
`define PF_LOG_QUEUE_SIZE 3

// block-aligned address width in bits
`define PF_ADDR_WIDTH 32

// block payload width in bits
`define PF_BLOCK_WIDTH 64

// watchdog prescale counter width
`define PF_WATCHDOG_WIDTH 10

`endif

/* common/prefetchTypesPkg.sv */
// Prefetcher base types
`default_nettype none
`include "prefetch_config.svh"

package prefetchTypesPkg;

    // block-aligned address
    typedef logic [`PF_ADDR_WIDTH-1:0] blockAddrT;

    // one block of payload
    typedef logic [`PF_BLOCK_WIDTH-1:0] blockDataT;

    // queue slot index
    typedef logic [`PF_LOG_QUEUE_SIZE-1:0] queueIdxT;

    // occupancy is one bit wider so a full queue fits
    typedef logic [`PF_LOG_QUEUE_SIZE:0] queueCntT;

    // watchdog prescale value
    typedef logic [`PF_WATCHDOG_WIDTH-1:0] prescaleT;

    // queue operations
    typedef enum logic [1:0] {
        opInvalidate = 2'd0,
        opRead       = 2'd1,
        opWriteReq   = 2'd2,
        opWriteResp  = 2'd3
    } queueOpT;

    // answer kinds for a demand read
    typedef enum logic [1:0] {
        lookupMiss    = 2'd0,
        lookupPending = 2'd1,
        lookupHit     = 2'd2
    } lookupKindT;

endpackage

`default_nettype wire

/* common/prefetchBusPkg.sv */
// Prefetcher bus structs
`default_nettype none

package prefetchBusPkg;

    import prefetchTypesPkg::*;

    // one operation offered to or granted into the queue
    typedef struct packed {
        logic      valid;
        queueOpT   op;
        blockAddrT addr;
        blockDataT data;
    } queueReqT;

    // registered answer to a demand read
    typedef struct packed {
        logic       valid;
        lookupKindT kind;
        blockAddrT  addr;
        blockDataT  data;
    } lookupResultT;

    // prefetch fetch toward DRAM, also the shape of a snoop invalidate
    typedef struct packed {
        logic      valid;
        blockAddrT addr;
    } dramReqT;

    // block returning from DRAM
    typedef struct packed {
        logic      valid;
        blockAddrT addr;
        blockDataT data;
    } dramRespT;

endpackage

`default_nettype wire

/* hw/prefetcherQueue/prefetcherQueue.sv */
// Prefetcher block queue
`timescale 1ns/10ps
`default_nettype none
`include "prefetch_config.svh"

module prefetcherQueue
    import prefetchTypesPkg::*;
    import prefetchBusPkg::*;
(
    input  logic         clk,
    input  logic         resetN,
    input  prescaleT     watchdogPrescale,
    input  queueReqT     grantedOp,
    output lookupResultT lookupResult,
    output dramReqT      dramReq,
    output queueCntT     outstandingCnt,
    output logic         queueFull
);

    localparam int QueueSize = 1 << `PF_LOG_QUEUE_SIZE;

    // slot payload
    blockAddrT slotAddr [QueueSize];
    blockDataT slotData [QueueSize];

    // slot flags
    logic [QueueSize-1:0] validVec;
    logic [QueueSize-1:0] dataValidVec;
    logic [QueueSize-1:0] outstandingVec;
    logic [QueueSize-1:0] staleVec;
    logic [QueueSize-1:0] validNext;
    logic [QueueSize-1:0] dataValidNext;
    logic [QueueSize-1:0] outstandingNext;
    logic [QueueSize-1:0] staleNext;

    // ring bookkeeping with tail at the next free slot
    queueIdxT headPtr;
    queueIdxT tailPtr;
    queueIdxT headNext;
    queueIdxT tailNext;
    queueCntT usedCnt;
    queueCntT usedNext;
    logic     queueEmpty;

    // address match and pop range
    logic                 addrHit;
    queueIdxT             matchIdx;
    queueIdxT             popDist;
    logic [QueueSize-1:0] olderMask;

    // decoded operation
    logic doRead;
    logic doPop;
    logic doFlush;
    logic doAppend;
    logic doFill;
    logic doInval;
    logic doAdvance;

    // watchdog divider
    prescaleT prescaleCnt;
    logic     watchdogTick;

    // lowest matching valid slot wins
    always_comb begin
        addrHit  = 1'b0;
        matchIdx = '0;
        for (int i = QueueSize - 1; i >= 0; i--) begin
            if (validVec[i] && (slotAddr[i] == grantedOp.addr)) begin
                addrHit  = 1'b1;
                matchIdx = queueIdxT'(i);
            end
        end
    end

    // slots between head and the matched slot are older
    always_comb begin
        popDist = matchIdx - headPtr;
        for (int i = 0; i < QueueSize; i++) begin
            olderMask[i] = (queueIdxT'(i) - headPtr) < popDist;
        end
    end

    assign queueFull  = (usedCnt == queueCntT'(QueueSize));
    assign queueEmpty = (usedCnt == '0);

    assign doRead   = grantedOp.valid && (grantedOp.op == opRead);
    assign doPop    = doRead && addrHit;
    assign doFlush  = doRead && !addrHit;
    // a block already queued is not fetched twice
    assign doAppend = grantedOp.valid && (grantedOp.op == opWriteReq) && !queueFull && !addrHit;
    assign doFill   = grantedOp.valid && (grantedOp.op == opWriteResp) && addrHit;
    assign doInval  = grantedOp.valid && (grantedOp.op == opInvalidate) && addrHit;
    // dead head slots are skipped one per cycle
    assign doAdvance = !doPop && !doFlush && !queueEmpty && !validVec[headPtr];

    // ticks once every watchdogPrescale + 1 cycles
    assign watchdogTick = (prescaleCnt >= watchdogPrescale);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            prescaleCnt <= '0;
        end else if (watchdogTick) begin
            prescaleCnt <= '0;
        end else begin
            prescaleCnt <= prescaleCnt + 1'b1;
        end
    end

    // next flag and pointer state
    always_comb begin
        validNext       = validVec;
        dataValidNext   = dataValidVec;
        outstandingNext = outstandingVec;
        staleNext       = staleVec;
        headNext        = headPtr;
        tailNext        = tailPtr;
        usedNext        = usedCnt;

        // evict what was already stale and mark the survivors
        if (watchdogTick) begin
            validNext = validVec & ~staleVec;
            staleNext = validVec & ~staleVec;
        end

        if (doAppend) begin
            validNext[tailPtr]       = 1'b1;
            dataValidNext[tailPtr]   = 1'b0;
            outstandingNext[tailPtr] = 1'b1;
            staleNext[tailPtr]       = 1'b0;
            tailNext                 = tailPtr + 1'b1;
            usedNext                 = usedCnt + 1'b1;
        end

        // a response touches the slot so it survives a tick in the same cycle
        if (doFill) begin
            validNext[matchIdx]       = 1'b1;
            dataValidNext[matchIdx]   = 1'b1;
            outstandingNext[matchIdx] = 1'b0;
            staleNext[matchIdx]       = 1'b0;
        end

        if (doInval) begin
            dataValidNext[matchIdx] = 1'b0;
        end

        // hit keeps its own slot and drops everything older
        if (doPop) begin
            validNext           = validNext & ~olderMask;
            validNext[matchIdx] = 1'b1;
            staleNext[matchIdx] = 1'b0;
            headNext            = matchIdx;
            usedNext            = usedCnt - queueCntT'(popDist);
        end

        if (doFlush) begin
            validNext = '0;
            headNext  = tailPtr;
            usedNext  = '0;
        end

        if (doAdvance) begin
            headNext = headPtr + 1'b1;
            usedNext = usedNext - 1'b1;
        end

        // dead slots carry no flags
        dataValidNext   = dataValidNext & validNext;
        outstandingNext = outstandingNext & validNext;
        staleNext       = staleNext & validNext;
    end

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            validVec       <= '0;
            dataValidVec   <= '0;
            outstandingVec <= '0;
            staleVec       <= '0;
            headPtr        <= '0;
            tailPtr        <= '0;
            usedCnt        <= '0;
        end else begin
            validVec       <= validNext;
            dataValidVec   <= dataValidNext;
            outstandingVec <= outstandingNext;
            staleVec       <= staleNext;
            headPtr        <= headNext;
            tailPtr        <= tailNext;
            usedCnt        <= usedNext;
        end
    end

    // slot payload
    always_ff @(posedge clk) begin
        if (doAppend) begin
            slotAddr[tailPtr] <= grantedOp.addr;
        end
        if (doFill) begin
            slotData[matchIdx] <= grantedOp.data;
        end
    end

    // read answer and DRAM fetch one cycle after the grant
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            lookupResult <= '0;
            dramReq      <= '0;
        end else begin
            lookupResult.valid <= doRead;
            lookupResult.addr  <= grantedOp.addr;
            if (!addrHit) begin
                lookupResult.kind <= lookupMiss;
                lookupResult.data <= '0;
            end else if (dataValidVec[matchIdx]) begin
                lookupResult.kind <= lookupHit;
                lookupResult.data <= slotData[matchIdx];
            end else begin
                lookupResult.kind <= lookupPending;
                lookupResult.data <= '0;
            end
            dramReq.valid <= doAppend;
            dramReq.addr  <= grantedOp.addr;
        end
    end

    // slots still waiting for DRAM
    always_comb begin
        outstandingCnt = '0;
        for (int i = 0; i < QueueSize; i++) begin
            outstandingCnt = outstandingCnt + queueCntT'(outstandingVec[i]);
        end
    end

    // head meets tail only in a full or an empty ring
    // an empty ring holds no live slot
    fullNotEmpty: assert property (@(posedge clk) disable iff (!resetN)
        (!queueFull || (headPtr == tailPtr))
        && (!queueEmpty || ((headPtr == tailPtr) && (validVec == '0))));

    // a fetch only claims a free tail slot, never one of a full ring
    noFetchWhenFull: assert property (@(posedge clk) disable iff (!resetN)
        dramReq.valid |-> !$past(validVec[tailPtr]));

endmodule

`default_nettype wire

/* hw/strideDetector.sv */
// Miss stride detector
`timescale 1ns/10ps
`default_nettype none

module strideDetector
    import prefetchTypesPkg::*;
    import prefetchBusPkg::*;
(
    input  logic         clk,
    input  logic         resetN,
    input  lookupResultT lookupResult,
    input  logic         queueFull,
    input  logic         prefetchTaken,
    output queueReqT     prefetchCand
);

    // training progress
    typedef enum logic [1:0] {
        stIdle,
        stOneMiss,
        stStrided,
        stStream
    } strideStateT;

    strideStateT state;
    blockAddrT   lastMiss;
    blockAddrT   lastStride;
    blockAddrT   nextAddr;
    blockAddrT   newStride;
    logic        candPending;
    logic        holdCand;
    logic        isMiss;
    logic        isQueued;

    assign newStride = lookupResult.addr - lastMiss;
    assign isMiss    = lookupResult.valid && (lookupResult.kind == lookupMiss);
    // pending counts too, the block is already on its way
    assign isQueued  = lookupResult.valid && (lookupResult.kind != lookupMiss);
    // an offered candidate is frozen until the arbiter takes it
    assign holdCand  = candPending && !prefetchTaken;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state       <= stIdle;
            lastMiss    <= '0;
            lastStride  <= '0;
            nextAddr    <= '0;
            candPending <= 1'b0;
        end else begin
            if (prefetchTaken) begin
                candPending <= 1'b0;
            end
            if (isMiss) begin
                lastMiss <= lookupResult.addr;
                if (state == stIdle) begin
                    state <= stOneMiss;
                end else if ((state != stOneMiss) && (newStride == lastStride)
                             && (newStride != '0)) begin
                    // confirmed, aim one stride past this miss
                    state <= stStream;
                    if (!holdCand) begin
                        nextAddr    <= lookupResult.addr + newStride;
                        candPending <= 1'b1;
                    end
                end else begin
                    // retrain on the new stride
                    lastStride  <= newStride;
                    state       <= (newStride != '0) ? stStrided : stOneMiss;
                    candPending <= 1'b0;
                end
            end else if (isQueued && (state == stStream) && !holdCand) begin
                // stay one block ahead of demand
                nextAddr    <= nextAddr + lastStride;
                candPending <= 1'b1;
            end
        end
    end

    // nothing is offered while the queue is full
    always_comb begin
        prefetchCand.valid = candPending && !queueFull;
        prefetchCand.op    = opWriteReq;
        prefetchCand.addr  = nextAddr;
        prefetchCand.data  = '0;
    end

    candStable: assert property (@(posedge clk) disable iff (!resetN)
        (prefetchCand.valid && !prefetchTaken) |=> (prefetchCand.addr == $past(prefetchCand.addr)));

endmodule

`default_nettype wire

/* hw/queueArbiter.sv */
// Queue port arbiter
`timescale 1ns/10ps
`default_nettype none

module queueArbiter
    import prefetchBusPkg::*;
(
    input  queueReqT respReq,
    input  queueReqT invalReq,
    input  queueReqT demandReq,
    input  queueReqT prefetchCand,
    output queueReqT grantedOp,
    output logic     demandStall,
    output logic     prefetchTaken
);

    // one grant bit per peer with the response highest
    logic grantResp;
    logic grantInval;
    logic grantDemand;
    logic grantPref;

    // DRAM returns always win so no block is lost
    assign grantResp   = respReq.valid;
    assign grantInval  = invalReq.valid && !respReq.valid;
    assign grantDemand = demandReq.valid && !respReq.valid && !invalReq.valid;
    assign grantPref   = prefetchCand.valid && !respReq.valid && !invalReq.valid
                         && !demandReq.valid;

    always_comb begin
        if (grantResp) begin
            grantedOp = respReq;
        end else if (grantInval) begin
            grantedOp = invalReq;
        end else if (grantDemand) begin
            grantedOp = demandReq;
        end else if (grantPref) begin
            grantedOp = prefetchCand;
        end else begin
            grantedOp = '0;
        end
    end

    // the cache holds a losing read and retries
    assign demandStall   = demandReq.valid && !grantDemand;
    assign prefetchTaken = grantPref;

endmodule

`default_nettype wire

/* hw/prefetcherTop.sv */
// Block prefetcher top level
`timescale 1ns/10ps
`default_nettype none

module prefetcherTop
    import prefetchTypesPkg::*;
    import prefetchBusPkg::*;
(
    input  logic         clk,
    input  logic         resetN,
    input  prescaleT     watchdogPrescale,
    input  queueReqT     demandReq,
    input  dramReqT      snoopInval,
    input  dramRespT     dramResp,
    output lookupResultT lookupResult,
    output dramReqT      dramReq,
    output logic         demandStall,
    output queueCntT     outstandingCnt,
    output logic         queueFull
);

    // opcode-tagged peers
    queueReqT respReq;
    queueReqT invalReq;
    queueReqT readReq;
    queueReqT prefetchCand;
    queueReqT grantedOp;
    logic     prefetchTaken;

    always_comb begin
        respReq.valid  = dramResp.valid;
        respReq.op     = opWriteResp;
        respReq.addr   = dramResp.addr;
        respReq.data   = dramResp.data;

        invalReq.valid = snoopInval.valid;
        invalReq.op    = opInvalidate;
        invalReq.addr  = snoopInval.addr;
        invalReq.data  = '0;

        // a demand lookup is always a read
        readReq.valid  = demandReq.valid;
        readReq.op     = opRead;
        readReq.addr   = demandReq.addr;
        readReq.data   = demandReq.data;
    end

    strideDetector u_stride (
        .clk          (clk),
        .resetN       (resetN),
        .lookupResult (lookupResult),
        .queueFull    (queueFull),
        .prefetchTaken(prefetchTaken),
        .prefetchCand (prefetchCand)
    );

    queueArbiter u_arb (
        .respReq      (respReq),
        .invalReq     (invalReq),
        .demandReq    (readReq),
        .prefetchCand (prefetchCand),
        .grantedOp    (grantedOp),
        .demandStall  (demandStall),
        .prefetchTaken(prefetchTaken)
    );

    prefetcherQueue u_queue (
        .clk             (clk),
        .resetN          (resetN),
        .watchdogPrescale(watchdogPrescale),
        .grantedOp       (grantedOp),
        .lookupResult    (lookupResult),
        .dramReq         (dramReq),
        .outstandingCnt  (outstandingCnt),
        .queueFull       (queueFull)
    );

endmodule

`default_nettype wire

/* verification/prefetcherTb.sv */
// Prefetcher testbench
`timescale 1ns/10ps
`default_nettype none

module prefetcherTb
    import prefetchTypesPkg::*;
    import prefetchBusPkg::*;
;

    localparam int MaxLines  = 256;
    localparam int NumInputs = 8;
    localparam int NumChecks = 8;

    // DUT ports
    logic         clk;
    logic         resetN;
    prescaleT     watchdogPrescale;
    queueReqT     demandReq;
    dramReqT      snoopInval;
    dramRespT     dramResp;
    lookupResultT lookupResult;
    dramReqT      dramReq;
    logic         demandStall;
    queueCntT     outstandingCnt;
    logic         queueFull;

    // one row of the tests file per cycle
    int          testNum [MaxLines];
    logic [63:0] inVal   [MaxLines][NumInputs];
    logic [63:0] expVal  [MaxLines][NumChecks];
    logic        expCare [MaxLines][NumChecks];
    int          numLines;
    logic        loadDone;

    // run totals and per-test totals
    int errorCount;
    int checkCount;
    int testErrors;
    int testChecks;
    int testsRun;

    prefetcherTop u_dut (
        .clk             (clk),
        .resetN          (resetN),
        .watchdogPrescale(watchdogPrescale),
        .demandReq       (demandReq),
        .snoopInval      (snoopInval),
        .dramResp        (dramResp),
        .lookupResult    (lookupResult),
        .dramReq         (dramReq),
        .demandStall     (demandStall),
        .outstandingCnt  (outstandingCnt),
        .queueFull       (queueFull)
    );

    // 20 ns clock
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // column order of the expected values
    function automatic string checkName(input int k);
        case (k)
            0:       return "lookupResult.valid";
            1:       return "lookupResult.kind";
            2:       return "lookupResult.data";
            3:       return "dramReq.valid";
            4:       return "dramReq.addr";
            5:       return "demandStall";
            6:       return "outstandingCnt";
            default: return "queueFull";
        endcase
    endfunction

    // a dash means the column is not checked
    function automatic void parseField(input string s, output logic [63:0] value,
                                       output logic care);
        int n;
        value = '0;
        care  = 1'b0;
        if (s != "-") begin
            n = $sscanf(s, "%h", value);
            if (n == 1) begin
                care = 1'b1;
            end else begin
                $display("unreadable expected value %s in the tests file", s);
                errorCount++;
            end
        end
    endfunction

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        checkCount++;
        testChecks++;
        if (actual !== expected) begin
            $display("CHECK FAILED %s: actual %h expected %h at %0t",
                     name, actual, expected, $time);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic loadTests();
        int          fd;
        int          n;
        int          t;
        string       line;
        string       f [NumChecks];
        logic [63:0] v [NumInputs];
        numLines = 0;
        fd = $fopen("verification/prefetch_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the tests file");
        end else begin
            while (!$feof(fd) && (numLines < MaxLines)) begin
                line = "";
                n = $fgets(line, fd);
                // comment lines are skipped and blank lines give no fields
                if ((n > 0) && (line.getc(0) != "#")) begin
                    n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %s %s %s %s %s %s %s %s",
                                t, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
                    if (n == 17) begin
                        testNum[numLines] = t;
                        for (int k = 0; k < NumInputs; k++) begin
                            inVal[numLines][k] = v[k];
                        end
                        for (int k = 0; k < NumChecks; k++) begin
                            parseField(f[k], expVal[numLines][k], expCare[numLines][k]);
                        end
                        numLines++;
                    end else if (n > 0) begin
                        $display("skipped a malformed line in the tests file");
                        errorCount++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic driveInputs(input int i);
        demandReq.valid        = inVal[i][0][0];
        demandReq.op           = opRead;
        demandReq.addr         = blockAddrT'(inVal[i][1]);
        demandReq.data         = '0;
        snoopInval.valid       = inVal[i][2][0];
        snoopInval.addr        = blockAddrT'(inVal[i][3]);
        dramResp.valid         = inVal[i][4][0];
        dramResp.addr          = blockAddrT'(inVal[i][5]);
        dramResp.data          = blockDataT'(inVal[i][6]);
        watchdogPrescale       = prescaleT'(inVal[i][7]);
    endtask

    task automatic reportTest(input int t);
        $display("test %0d %s, %0d checks, %0d mismatches",
                 t, (testErrors == 0) ? "passed" : "failed", testChecks, testErrors);
        testsRun++;
        testErrors = 0;
        testChecks = 0;
    endtask

    // ends a hung run after two cycles per line plus a margin
    initial begin : timeoutWatch
        wait (loadDone);
        #(40.0 * numLines + 500.0);
        $display("timeout, the test sequence did not finish in time");
        $display("Errors found");
        $finish;
    end

    initial begin : mainSequence
        int          curTest;
        logic [63:0] act [NumChecks];
        resetN           = 1'b0;
        watchdogPrescale = '1;
        demandReq        = '0;
        snoopInval       = '0;
        dramResp         = '0;
        errorCount       = 0;
        checkCount       = 0;
        testErrors       = 0;
        testChecks       = 0;
        testsRun         = 0;
        loadDone         = 1'b0;
        loadTests();
        loadDone = 1'b1;
        repeat (2) @(posedge clk);
        #2;
        resetN  = 1'b1;
        curTest = testNum[0];
        for (int i = 0; i < numLines; i++) begin
            if (testNum[i] != curTest) begin
                reportTest(curTest);
                curTest = testNum[i];
            end
            driveInputs(i);
            // sample just before the next rising edge
            #17;
            act[0] = 64'(lookupResult.valid);
            act[1] = 64'(lookupResult.kind);
            act[2] = 64'(lookupResult.data);
            act[3] = 64'(dramReq.valid);
            act[4] = 64'(dramReq.addr);
            act[5] = 64'(demandStall);
            act[6] = 64'(outstandingCnt);
            act[7] = 64'(queueFull);
            for (int k = 0; k < NumChecks; k++) begin
                if (expCare[i][k]) begin
                    checkValue(checkName(k), act[k], expVal[i][k]);
                end
            end
            // a valid answer names the read granted on the line before
            if ((i > 0) && expCare[i][0] && expVal[i][0][0]) begin
                checkValue("lookupResult.addr", 64'(lookupResult.addr), inVal[i-1][1]);
            end
            @(posedge clk);
            #2;
        end
        if (numLines > 0) begin
            reportTest(curTest);
        end else begin
            $display("no test lines were read");
        end
        $display("%0d tests, %0d checks, %0d errors", testsRun, checkCount, errorCount);
        if ((errorCount == 0) && (numLines > 0)) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/prefetch_tests.txt */
# test dV dAddr iV iAddr rV rAddr rData prescale | expected: lkValid lkKind lkData
# dramValid dramAddr demandStall outstandingCnt queueFull; a dash is not checked
1 1 100 0 0 0 0 0 3ff 0 - - 0 - 0 0 0
1 1 110 0 0 0 0 0 3ff 1 0 0 0 - 0 0 0
1 1 120 0 0 0 0 0 3ff 1 0 0 0 - 0 0 0
1 0 0 0 0 0 0 0 3ff 1 0 0 0 - 0 0 0
1 0 0 0 0 0 0 0 3ff 0 - - 0 - 0 0 0
1 0 0 0 0 0 0 0 3ff 0 - - 1 130 0 1 0
2 1 130 0 0 0 0 0 3ff 0 - - 0 - 0 1 0
2 0 0 0 0 1 130 cafe0001 3ff 1 1 0 0 - 0 1 0
2 1 130 0 0 0 0 0 3ff 0 - - 0 - 0 0 0
2 0 0 0 0 0 0 0 3ff 1 2 cafe0001 0 - 0 0 0
2 0 0 0 0 0 0 0 3ff 0 - - 1 140 0 1 0
2 0 0 0 0 0 0 0 3ff 0 - - 1 150 0 2 0
3 1 150 0 0 0 0 0 3ff 0 - - 0 - 0 2 0
3 1 140 0 0 0 0 0 3ff 1 1 0 0 - 0 1 0
3 0 0 0 0 0 0 0 3ff 1 0 0 0 - 0 0 0
3 0 0 0 0 0 0 0 3ff 0 - - 1 160 0 1 0
4 1 160 0 0 1 160 beef0002 3ff 0 - - 0 - 1 1 0
4 1 160 0 0 0 0 0 3ff 0 - - 0 - 0 0 0
4 0 0 1 160 0 0 0 3ff 1 2 beef0002 0 - 0 0 0
4 1 160 0 0 0 0 0 3ff 0 - - 0 - 0 0 0
4 0 0 0 0 0 0 0 3ff 1 1 0 0 - 0 0 0
5 1 200 0 0 0 0 0 3ff 0 - - 0 - 0 0 0
5 1 220 0 0 0 0 0 3ff 1 0 0 0 - 0 0 0
5 1 240 0 0 0 0 0 3ff 1 0 0 0 - 0 0 0
5 0 0 0 0 0 0 0 3ff 1 0 0 0 - 0 0 0
5 0 0 0 0 0 0 0 3ff 0 - - 0 - 0 0 0
5 1 260 0 0 0 0 0 3ff 0 - - 1 260 0 1 0
5 0 0 0 0 0 0 0 3ff 1 1 0 0 - 0 1 0
5 1 260 0 0 0 0 0 3ff 0 - - 0 - 0 1 0
5 0 0 0 0 0 0 0 3ff 1 1 0 0 - 0 1 0
5 1 260 0 0 0 0 0 3ff 0 - - 1 280 0 2 0
5 0 0 0 0 0 0 0 3ff 1 1 0 0 - 0 2 0
5 1 260 0 0 0 0 0 3ff 0 - - 1 2a0 0 3 0
5 0 0 0 0 0 0 0 3ff 1 1 0 0 - 0 3 0
5 1 260 0 0 0 0 0 3ff 0 - - 1 2c0 0 4 0
5 0 0 0 0 0 0 0 3ff 1 1 0 0 - 0 4 0
5 1 260 0 0 0 0 0 3ff 0 - - 1 2e0 0 5 0
5 0 0 0 0 0 0 0 3ff 1 1 0 0 - 0 5 0
5 1 260 0 0 0 0 0 3ff 0 - - 1 300 0 6 0
5 0 0 0 0 0 0 0 3ff 1 1 0 0 - 0 6 0
5 1 260 0 0 0 0 0 3ff 0 - - 1 320 0 7 0
5 0 0 0 0 0 0 0 3ff 1 1 0 0 - 0 7 0
5 1 260 0 0 0 0 0 3ff 0 - - 1 340 0 8 1
5 0 0 0 0 0 0 0 3ff 1 1 0 0 - 0 8 1
5 0 0 0 0 0 0 0 3ff 0 - - 0 - 0 8 1
6 0 0 0 0 0 0 0 3 0 - - 0 - 0 8 1
6 0 0 0 0 0 0 0 3 0 - - 0 - 0 8 1
6 1 260 0 0 0 0 0 3 0 - - 0 - 0 8 1
6 0 0 0 0 0 0 0 3 1 1 0 0 - 0 8 1
6 0 0 0 0 0 0 0 3 0 - - 0 - 0 8 1
6 0 0 0 0 0 0 0 3 0 - - 0 - 0 1 1
6 1 260 0 0 0 0 0 3 0 - - 0 - 0 1 1
6 0 0 0 0 0 0 0 3 1 1 0 0 - 0 1 1
6 1 280 0 0 0 0 0 3 0 - - 0 - 0 1 1
6 0 0 0 0 0 0 0 3 1 0 0 0 - 0 0 0

/* vlog.f */
+incdir+common
common/prefetchTypesPkg.sv
common/prefetchBusPkg.sv
hw/prefetcherQueue/prefetcherQueue.sv
hw/strideDetector.sv
hw/queueArbiter.sv
hw/prefetcherTop.sv
verification/prefetcherTb.sv

/* Bender.yml */
package:
  name: prefetcher

sources:
  - include_dirs:
      - common
    files:
      - common/prefetchTypesPkg.sv
      - common/prefetchBusPkg.sv
      - hw/prefetcherQueue/prefetcherQueue.sv
      - hw/strideDetector.sv
      - hw/queueArbiter.sv
      - hw/prefetcherTop.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/prefetcherTb.sv
